// ==== vgaWindow.f ====
verilog/vgaPkg.sv
verilog/vgaTiming.sv
verilog/pixelDecode.sv
verilog/channelExpand.sv
verilog/videoOut.sv
verilog/vgaWindowTop.sv
tb/clockGen.sv
tb/vgaWindowTb.sv

// ==== Bender.yml ====
package:
  name: vgaWindow

sources:
  - verilog/vgaPkg.sv
  - verilog/vgaTiming.sv
  - verilog/pixelDecode.sv
  - verilog/channelExpand.sv
  - verilog/videoOut.sv
  - verilog/vgaWindowTop.sv
  - target: test
    files:
      - tb/clockGen.sv
      - tb/vgaWindowTb.sv

// ==== tb/vgaWindowTb.sv ====
// vgaWindowTb: random frame memory and palette stimulus with a raster reference model
`timescale 1ns/1ps

module vgaWindowTb;
    import vgaPkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;        // 420000 per frame
    localparam int OUT_LAT      = PIPE_DEPTH + 2;            // release-counted edges to pins
    localparam int RUN_CYCLES   = 2 * FRAME_CYCLES + OUT_LAT;
    localparam int CYCLE_LIMIT  = 2 * FRAME_CYCLES + 2000;   // two frames plus margin

    logic              clk_25_vga;
    logic              arstN;
    logic [ADDR_W-1:0] pixelAddress;
    logic              fetchEn;
    logic [PIX_W-1:0]  pixelData;
    colorMode_e        colorMode;
    logic              palWrEn;
    logic [7:0]        palWrAddr;
    logic [15:0]       palWrData;
    logic              hsync;
    logic              vsync;
    logic              blankN;
    logic [7:0]        red;
    logic [7:0]        green;
    logic [7:0]        blue;

    logic [31:0]       lfsrState = 32'heb436ccc;
    logic [15:0]       memSalt;                  // drawn once, mixes the memory contents
    logic [15:0]       palModel [256];           // host view of the palette
    logic [ADDR_W-1:0] pendAddr;                 // address waiting for its data
    logic              pendValid = 1'b0;
    bit                started = 1'b0;
    int                sinceRelease = 0;         // edges after reset release
    int                cycleCount = 0;
    int                errCount [4] = '{0, 0, 0, 0};   // sync, blank, colour, fetch

    clockGen clkInst (
        .clk_25_vga (clk_25_vga),
        .arstN      (arstN)
    );

    vgaWindowTop vgaWindowTop_inst (
        .clk_25_vga   (clk_25_vga),
        .arstN        (arstN),
        .pixelAddress (pixelAddress),
        .fetchEn      (fetchEn),
        .pixelData    (pixelData),
        .colorMode    (colorMode),
        .palWrEn      (palWrEn),
        .palWrAddr    (palWrAddr),
        .palWrData    (palWrData),
        .hsync        (hsync),
        .vsync        (vsync),
        .blankN       (blankN),
        .red          (red),
        .green        (green),
        .blue         (blue)
    );

    // Galois LFSR, x^32+x^22+x^2+x+1, one step per bit taken
    task automatic drawBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
        end
    endtask

    function automatic logic [15:0] memWord(input logic [ADDR_W-1:0] a);
        logic [31:0] prod;
        prod = 32'(a) * 32'h9e37;               // high half carries the top address bits
        return prod[15:0] ^ prod[31:16] ^ memSalt;
    endfunction

    // rgb565 to 8/8/8, high bits repeated into the low bits
    function automatic logic [23:0] expandRgb(input logic [15:0] c);
        return {c[15:11], c[15:13], c[10:5], c[10:9], c[4:0], c[4:2]};
    endfunction

    function automatic bit inWin(input int q);
        int c;
        int l;
        c = q % H_TOTAL;
        l = (q / H_TOTAL) % V_TOTAL;
        return (q >= 0) && (c >= WIN_X0) && (c < WIN_X0 + WIN_W) &&
               (l >= WIN_Y0) && (l < WIN_Y0 + WIN_H);
    endfunction

    function automatic logic [ADDR_W-1:0] winAddr(input int q);
        return ADDR_W'(((q / H_TOTAL) % V_TOTAL - WIN_Y0) * WIN_W + q % H_TOTAL - WIN_X0);
    endfunction

    // frame 1 direct, frame 2 through the palette
    function automatic logic [23:0] expectColour(input int frame, input logic [ADDR_W-1:0] a);
        pixelWord_u w;
        w = memWord(a);
        if (frame == 0) begin
            return expandRgb(w);
        end
        if (w.indexed.attr[0]) begin
            return 24'h0;                        // blackOut
        end
        return expandRgb(palModel[w.indexed.index]);
    endfunction

    task automatic checkValue(input int group, input string name, input logic [31:0] expVal,
                              input logic [31:0] gotVal, input int q);
        if (gotVal !== expVal) begin
            errCount[group]++;
            if (q < 0) begin
                $display("[ERROR] %s expected 0x%0h got 0x%0h before first pipeline output",
                         name, expVal, gotVal);
            end else begin
                $display("[ERROR] %s expected 0x%0h got 0x%0h at frame %0d line %0d col %0d",
                         name, expVal, gotVal, q / FRAME_CYCLES, (q / H_TOTAL) % V_TOTAL,
                         q % H_TOTAL);
            end
        end
    endtask

    task automatic writePalette(input logic [7:0] a, input logic [15:0] d);
        palWrEn   = 1'b1;
        palWrAddr = a;
        palWrData = d;
        palModel[a] = d;
        @(negedge clk_25_vga);
        palWrEn   = 1'b0;
    endtask

    always @(posedge clk_25_vga) begin
        cycleCount <= cycleCount + 1;
        if (arstN) begin
            sinceRelease <= sinceRelease + 1;
            started      <= 1'b1;
        end
    end

    // checks and frame memory, all on the falling edge
    always @(negedge clk_25_vga) begin : checkStep
        int          q;
        int          c;
        int          l;
        logic        expHs;
        logic        expVs;
        logic        expBk;
        logic [23:0] expRgb;
        q = sinceRelease - 1;                    // position now on the fetch port
        checkValue(3, "fetchEn", inWin(q), fetchEn, q);
        if (inWin(q)) begin
            checkValue(3, "pixelAddress", winAddr(q), pixelAddress, q);
        end
        q = sinceRelease - OUT_LAT;              // position now on the DAC pins
        if (q < 0) begin
            expHs  = 1'b1;                       // idle outputs
            expVs  = 1'b1;
            expBk  = 1'b0;
            expRgb = 24'h0;
        end else begin
            c = q % H_TOTAL;
            l = (q / H_TOTAL) % V_TOTAL;
            expHs  = !(c >= H_DISPLAY + H_FRONT && c < H_DISPLAY + H_FRONT + H_SYNC);
            expVs  = !(l >= V_DISPLAY + V_FRONT && l < V_DISPLAY + V_FRONT + V_SYNC);
            expBk  = (c < H_DISPLAY) && (l < V_DISPLAY);
            expRgb = inWin(q) ? expectColour(q / FRAME_CYCLES, winAddr(q)) : 24'h0;
        end
        checkValue(0, "hsync", expHs, hsync, q);
        checkValue(0, "vsync", expVs, vsync, q);
        checkValue(1, "blankN", expBk, blankN, q);
        checkValue(2, "red", expRgb[23:16], red, q);
        checkValue(2, "green", expRgb[15:8], green, q);
        checkValue(2, "blue", expRgb[7:0], blue, q);
        pixelData = pendValid ? memWord(pendAddr) : '0;  // one cycle after the address
        pendValid = started && fetchEn;
        pendAddr  = pixelAddress;
    end

    initial begin : stimulus
        logic [31:0] bits;
        logic [31:0] addrBits;
        int          total;
        pixelData = '0;
        colorMode = DIRECT;
        palWrEn   = 1'b0;
        palWrAddr = '0;
        palWrData = '0;
        drawBits(16, bits);
        memSalt = bits[15:0];
        wait (started);
        @(negedge clk_25_vga);
        for (int i = 0; i < 256; i++) begin      // full palette during frame 1 top lines
            drawBits(16, bits);
            writePalette(8'(i), bits[15:0]);
        end
        while (sinceRelease < (V_DISPLAY + 5) * H_TOTAL) begin
            @(negedge clk_25_vga);
        end
        colorMode = PALETTE;                     // in vertical blanking of frame 1
        for (int i = 0; i < 64; i++) begin       // rewrite, must show in frame 2
            drawBits(8, addrBits);
            drawBits(16, bits);
            writePalette(addrBits[7:0], bits[15:0]);
        end
        while (sinceRelease < RUN_CYCLES) begin
            @(posedge clk_25_vga);
        end
        total = errCount[0] + errCount[1] + errCount[2] + errCount[3];
        $display("errors: sync %0d, blank %0d, colour %0d, fetch %0d, total %0d",
                 errCount[0], errCount[1], errCount[2], errCount[3], total);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clk_25_vga);
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb/clockGen.sv ====
// clockGen: 10 ns testbench pixel clock and 3-cycle active-low reset
`timescale 1ns/1ps

module clockGen #(
    parameter real PERIOD     = 10.0,  // ns
    parameter int  RST_CYCLES = 3      // rising edges held in reset
) (
    output logic clk_25_vga,
    output logic arstN
);

    initial begin
        clk_25_vga = 1'b0;
        forever #(PERIOD / 2.0) clk_25_vga = ~clk_25_vga;
    end

    initial begin
        arstN = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_25_vga);
        @(negedge clk_25_vga);
        arstN = 1'b1;                  // release on the falling edge
    end

endmodule

// ==== verilog/vgaWindowTop.sv ====
// vgaWindowTop: 320x240 windowed VGA display pipeline to a video DAC
`timescale 1ns/1ps

module vgaWindowTop #(
    parameter int OUT_W = 8            // DAC bits per channel
) (
    input  logic                      clk_25_vga,
    input  logic                      arstN,
    output logic [vgaPkg::ADDR_W-1:0] pixelAddress,
    output logic                      fetchEn,
    input  logic [vgaPkg::PIX_W-1:0]  pixelData,
    input  vgaPkg::colorMode_e        colorMode,
    input  logic                      palWrEn,
    input  logic [7:0]                palWrAddr,
    input  logic [15:0]               palWrData,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      blankN,
    output logic [OUT_W-1:0]          red,
    output logic [OUT_W-1:0]          green,
    output logic [OUT_W-1:0]          blue
);
    import vgaPkg::*;

    logic             tHsync;          // timing stage outputs
    logic             tVsync;
    logic             tBlankN;
    logic             tInWindow;
    logic [PIX_W-1:0] fieldWord;       // red | green | blue, 5/6/5
    logic [OUT_W-1:0] levels [3];      // 0 red, 1 green, 2 blue

    vgaTiming timingInst (
        .clk_25_vga   (clk_25_vga),
        .arstN        (arstN),
        .hsync        (tHsync),
        .vsync        (tVsync),
        .blankN       (tBlankN),
        .inWindow     (tInWindow),
        .fetchEn      (fetchEn),
        .pixelAddress (pixelAddress)
    );

    pixelDecode decodeInst (
        .clk_25_vga (clk_25_vga),
        .arstN      (arstN),
        .colorMode  (colorMode),
        .pixelData  (pixelData),
        .palWrEn    (palWrEn),
        .palWrAddr  (palWrAddr),
        .palWrData  (palWrData),
        .redField   (fieldWord[15:11]),
        .greenField (fieldWord[10:5]),
        .blueField  (fieldWord[4:0])
    );

    for (genvar ch = 0; ch < 3; ch++) begin : genChannel
        localparam int FW  = (ch == 1) ? 6 : 5;                      // green is wider
        localparam int LSB = (ch == 0) ? 11 : ((ch == 1) ? 5 : 0);   // slice in fieldWord
        channelExpand #(
            .FIELD_W (FW),
            .OUT_W   (OUT_W)
        ) expandInst (
            .clk_25_vga (clk_25_vga),
            .arstN      (arstN),
            .field      (fieldWord[LSB +: FW]),
            .level      (levels[ch])
        );
    end

    videoOut #(
        .OUT_W (OUT_W)
    ) outInst (
        .clk_25_vga (clk_25_vga),
        .arstN      (arstN),
        .hsyncIn    (tHsync),
        .vsyncIn    (tVsync),
        .blankNIn   (tBlankN),
        .inWindow   (tInWindow),
        .redLevel   (levels[0]),
        .greenLevel (levels[1]),
        .blueLevel  (levels[2]),
        .hsync      (hsync),
        .vsync      (vsync),
        .blankN     (blankN),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

endmodule

// ==== verilog/videoOut.sv ====
// videoOut: aligns syncs and blanking with the colour path and drives the DAC
`timescale 1ns/1ps

module videoOut #(
    parameter int OUT_W = 8            // DAC bits
) (
    input  logic             clk_25_vga,
    input  logic             arstN,
    input  logic             hsyncIn,
    input  logic             vsyncIn,
    input  logic             blankNIn,
    input  logic             inWindow,
    input  logic [OUT_W-1:0] redLevel,
    input  logic [OUT_W-1:0] greenLevel,
    input  logic [OUT_W-1:0] blueLevel,
    output logic             hsync,
    output logic             vsync,
    output logic             blankN,
    output logic [OUT_W-1:0] red,
    output logic [OUT_W-1:0] green,
    output logic [OUT_W-1:0] blue
);
    import vgaPkg::*;

    logic [PIPE_DEPTH-1:0] hsyncDly;   // shift lines, msb is oldest
    logic [PIPE_DEPTH-1:0] vsyncDly;
    logic [PIPE_DEPTH-1:0] blankNDly;
    logic [PIPE_DEPTH-1:0] windowDly;
    logic                  showPixel;

    assign showPixel = windowDly[PIPE_DEPTH-1];   // lines up with levels

    always_ff @(posedge clk_25_vga or negedge arstN) begin
        if (!arstN) begin
            hsyncDly  <= '1;           // idle high
            vsyncDly  <= '1;
            blankNDly <= '0;
            windowDly <= '0;
            hsync     <= 1'b1;
            vsync     <= 1'b1;
            blankN    <= 1'b0;
            red       <= '0;
            green     <= '0;
            blue      <= '0;
        end else begin
            hsyncDly  <= {hsyncDly[PIPE_DEPTH-2:0], hsyncIn};
            vsyncDly  <= {vsyncDly[PIPE_DEPTH-2:0], vsyncIn};
            blankNDly <= {blankNDly[PIPE_DEPTH-2:0], blankNIn};
            windowDly <= {windowDly[PIPE_DEPTH-2:0], inWindow};
            hsync     <= hsyncDly[PIPE_DEPTH-1];
            vsync     <= vsyncDly[PIPE_DEPTH-1];
            blankN    <= blankNDly[PIPE_DEPTH-1];
            red       <= showPixel ? redLevel   : '0;     // black outside window
            green     <= showPixel ? greenLevel : '0;
            blue      <= showPixel ? blueLevel  : '0;
        end
    end

    // window must sit inside the visible area, so blanking means black
    assert property (@(posedge clk_25_vga) disable iff (!arstN)
        !blankNDly[PIPE_DEPTH-1] |=> (red == '0) && (green == '0) && (blue == '0));

endmodule

// ==== verilog/channelExpand.sv ====
// channelExpand: bit-replicating widener from a colour field to DAC width
`timescale 1ns/1ps

module channelExpand #(
    parameter int FIELD_W = 5,         // 5 red/blue, 6 green
    parameter int OUT_W   = 8          // DAC bits
) (
    input  logic               clk_25_vga,
    input  logic               arstN,
    input  logic [FIELD_W-1:0] field,
    output logic [OUT_W-1:0]   level
);

    logic [OUT_W-1:0] expanded;

    // repeat the field from the MSB down, so all ones maps to full scale
    always_comb begin
        for (int i = 0; i < OUT_W; i++) begin
            expanded[OUT_W-1-i] = field[FIELD_W-1-(i % FIELD_W)];
        end
    end

    always_ff @(posedge clk_25_vga or negedge arstN) begin
        if (!arstN) begin
            level <= '0;
        end else begin
            level <= expanded;
        end
    end

endmodule

// ==== verilog/pixelDecode.sv ====
// pixelDecode: host-written palette and RGB565 / indexed decode of frame words
`timescale 1ns/1ps

module pixelDecode (
    input  logic                clk_25_vga,
    input  logic                arstN,
    input  vgaPkg::colorMode_e  colorMode,
    input  vgaPkg::pixelWord_u  pixelData,
    input  logic                palWrEn,
    input  logic [7:0]          palWrAddr,
    input  logic [15:0]         palWrData,
    output logic [4:0]          redField,
    output logic [5:0]          greenField,
    output logic [4:0]          blueField
);
    import vgaPkg::*;

    localparam int PAL_DEPTH = 256;

    rgb565_s palette [PAL_DEPTH];      // entries are RGB565 themselves
    rgb565_s palEntry;
    rgb565_s decoded;

    always_ff @(posedge clk_25_vga) begin
        if (palWrEn) begin
            palette[palWrAddr] <= palWrData;   // seen by lookups next cycle
        end
    end

    assign palEntry = palette[pixelData.indexed.index];    // async read

    always_comb begin
        if (colorMode == DIRECT) begin
            decoded = pixelData.rgb;           // word is the colour
        end else if (pixelData.indexed.attr[0]) begin
            decoded = '0;                      // blackOut
        end else begin
            decoded = palEntry;
        end
    end

    always_ff @(posedge clk_25_vga or negedge arstN) begin
        if (!arstN) begin
            redField   <= '0;
            greenField <= '0;
            blueField  <= '0;
        end else begin
            redField   <= decoded.red;
            greenField <= decoded.green;
            blueField  <= decoded.blue;
        end
    end

    // host writes must target a defined entry
    assert property (@(posedge clk_25_vga) disable iff (!arstN)
        palWrEn |-> !$isunknown(palWrAddr));

endmodule

// ==== verilog/vgaTiming.sv ====
// vgaTiming: 640x480 sync, blanking and window fetch address generator
`timescale 1ns/1ps

module vgaTiming (
    input  logic                      clk_25_vga,
    input  logic                      arstN,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      blankN,
    output logic                      inWindow,
    output logic                      fetchEn,
    output logic [vgaPkg::ADDR_W-1:0] pixelAddress
);
    import vgaPkg::*;

    localparam int H_CNT_W = $clog2(H_TOTAL);
    localparam int V_CNT_W = $clog2(V_TOTAL);

    logic [H_CNT_W-1:0] hCount;        // current column
    logic [V_CNT_W-1:0] vCount;        // current line
    logic [ADDR_W-1:0]  addrCount;     // next window word to fetch
    logic               lineEnd;
    logic               frameEnd;
    logic               hsyncNow;
    logic               vsyncNow;
    logic               visibleNow;
    logic               windowNow;

    assign lineEnd  = (hCount == H_CNT_W'(H_TOTAL - 1));
    assign frameEnd = lineEnd && (vCount == V_CNT_W'(V_TOTAL - 1));

    // decode of the current counter position
    assign hsyncNow   = (hCount >= H_CNT_W'(H_DISPLAY + H_FRONT)) &&
                        (hCount <  H_CNT_W'(H_DISPLAY + H_FRONT + H_SYNC));     // 656..751
    assign vsyncNow   = (vCount >= V_CNT_W'(V_DISPLAY + V_FRONT)) &&
                        (vCount <  V_CNT_W'(V_DISPLAY + V_FRONT + V_SYNC));     // 490..491
    assign visibleNow = (hCount < H_CNT_W'(H_DISPLAY)) && (vCount < V_CNT_W'(V_DISPLAY));
    assign windowNow  = (hCount >= H_CNT_W'(WIN_X0)) && (hCount < H_CNT_W'(WIN_X0 + WIN_W)) &&
                        (vCount >= V_CNT_W'(WIN_Y0)) && (vCount < V_CNT_W'(WIN_Y0 + WIN_H));

    always_ff @(posedge clk_25_vga or negedge arstN) begin
        if (!arstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;              // wrap column
            if (frameEnd) begin
                vCount <= '0;          // wrap line
            end else begin
                vCount <= vCount + 1'b1;
            end
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    // raster order within the window gives (line-120)*320 + (column-160)
    always_ff @(posedge clk_25_vga or negedge arstN) begin
        if (!arstN) begin
            addrCount <= '0;
        end else if (frameEnd) begin
            addrCount <= '0;           // restart at frame top
        end else if (windowNow) begin
            addrCount <= addrCount + 1'b1;
        end
    end

    always_ff @(posedge clk_25_vga) begin
        if (windowNow) begin
            pixelAddress <= addrCount; // held outside the window
        end
    end

    always_ff @(posedge clk_25_vga or negedge arstN) begin
        if (!arstN) begin
            hsync    <= 1'b1;          // idle high
            vsync    <= 1'b1;
            blankN   <= 1'b0;
            inWindow <= 1'b0;
            fetchEn  <= 1'b0;
        end else begin
            hsync    <= ~hsyncNow;
            vsync    <= ~vsyncNow;
            blankN   <= visibleNow;
            inWindow <= windowNow;
            fetchEn  <= windowNow;     // address valid this cycle
        end
    end

    // a fetch never runs past the last window word
    assert property (@(posedge clk_25_vga) disable iff (!arstN)
        fetchEn |-> (pixelAddress < ADDR_W'(WIN_W * WIN_H)));

    // sync pulse lies in the blanked part of the line
    assert property (@(posedge clk_25_vga) disable iff (!arstN)
        blankN |-> hsync);

endmodule

// ==== verilog/vgaPkg.sv ====
// vgaPkg: shared VGA timing constants, window geometry and pixel word views
package vgaPkg;

    // horizontal timing, in pixel clocks
    localparam int H_TOTAL   = 800;    // clocks per line
    localparam int H_DISPLAY = 640;    // visible columns
    localparam int H_FRONT   = 16;     // front porch
    localparam int H_SYNC    = 96;     // sync pulse width

    // vertical timing, in lines
    localparam int V_TOTAL   = 525;    // lines per frame
    localparam int V_DISPLAY = 480;    // visible lines
    localparam int V_FRONT   = 10;     // front porch
    localparam int V_SYNC    = 2;      // sync pulse width

    localparam int WIN_X0 = 160;       // window left column
    localparam int WIN_Y0 = 120;       // window top line
    localparam int WIN_W  = 320;       // window width
    localparam int WIN_H  = 240;       // window height

    localparam int ADDR_W = 17;        // 76800 words fit
    localparam int PIX_W  = 16;        // frame memory word

    localparam int PIPE_DEPTH = 3;     // memory + decode + expand

    typedef struct packed {
        logic [4:0] red;               // high bits
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_s;

    typedef struct packed {
        logic [7:0] attr;              // bit 0 is blackOut, rest ignored
        logic [7:0] index;             // palette entry
    } indexed_s;

    typedef union packed {
        rgb565_s  rgb;                 // direct colour view
        indexed_s indexed;             // palette view
    } pixelWord_u;

    typedef enum logic {
        DIRECT  = 1'b0,
        PALETTE = 1'b1
    } colorMode_e;

endpackage
